// ==== beat_delay.sv ====
`timescale 1ns/1ns

module beat_delay
    import pkt_pkg::*;
#(
    parameter type T = beat_t
) (
    input  logic clk,
    input  logic rst,
    input  T     d,
    output T     q
);

    T stage [BUF_DEPTH];

    // cleared fully so no stale valid beat drains out after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BUF_DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < BUF_DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[BUF_DEPTH-1];

endmodule

// ==== hdr_csum_unit.sv ====
`timescale 1ns/1ns

module hdr_csum_unit
    import pkt_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [PHIT_W-1:0] in_data,
    input  logic [LANES-1:0]  in_valid,
    input  logic              in_last,
    input  logic              enable,
    input  logic [LEN_W-1:0]  pkt_len,
    output beat_t             beat,
    output logic [CSUM_W-1:0] csum
);

    logic              in_pkt;
    logic              beat_present;
    logic              hdr_beat;
    logic              flag_hdr;
    logic [PHIT_W-1:0] sub_data;
    logic [CSUM_W-1:0] words [HDR_WORDS];

    // adder tree stages
    logic [SUM_W-1:0]  s1 [HDR_WORDS/2];
    logic [SUM_W-1:0]  s2 [3];
    logic [SUM_W-1:0]  s3 [2];
    logic [SUM_W-1:0]  s4;
    logic [CSUM_W:0]   fold1;
    logic [CSUM_W-1:0] fold2;

    assign beat_present = |in_valid;
    assign hdr_beat     = beat_present && !in_pkt;
    // enable and length only matter on the header beat itself
    assign flag_hdr     = hdr_beat && enable;

    // start-of-packet tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt <= 1'b0;
        end else if (beat_present) begin
            in_pkt <= !in_last;
        end
    end

    always_comb begin
        sub_data = in_data;
        if (flag_hdr) begin
            sub_data[LEN_LSB +: LEN_W] = pkt_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat.valid  <= '0;
            beat.last   <= 1'b0;
            beat.is_hdr <= 1'b0;
        end else begin
            beat.valid  <= in_valid;
            beat.last   <= in_last;
            beat.is_hdr <= flag_hdr;
        end
        beat.data <= sub_data;
    end

    // header words with length substituted and checksum zeroed
    always_comb begin
        for (int i = 0; i < HDR_WORDS; i++) begin
            words[i] = in_data[CSUM_W*i +: CSUM_W];
        end
        words[LEN_LSB/CSUM_W]  = pkt_len;
        words[CSUM_LSB/CSUM_W] = '0;
    end

    // end-around carry, two passes are enough for a 20-bit sum
    always_comb begin
        fold1 = (CSUM_W+1)'(s4[CSUM_W-1:0]) + (CSUM_W+1)'(s4[SUM_W-1:CSUM_W]);
        fold2 = fold1[CSUM_W-1:0] + CSUM_W'(fold1[CSUM_W]);
    end

    // runs on every beat, the consumer picks the header result
    always_ff @(posedge clk) begin
        for (int i = 0; i < HDR_WORDS/2; i++) begin
            s1[i] <= SUM_W'(words[2*i]) + SUM_W'(words[2*i+1]);
        end
        s2[0] <= s1[0] + s1[1];
        s2[1] <= s1[2] + s1[3];
        s2[2] <= s1[4];
        s3[0] <= s2[0] + s2[1];
        s3[1] <= s2[2];
        s4    <= s3[0] + s3[1];
        csum  <= ~fold2;
    end

endmodule

// ==== packet_rewrap.sv ====
`timescale 1ns/1ns

module packet_rewrap
    import pkt_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  beat_t             beat,
    input  logic [CSUM_W-1:0] csum,
    output logic [PHIT_W-1:0] out_data,
    output logic [LANES-1:0]  out_valid,
    output logic              out_last,
    output logic              pkt_done
);

    logic [PHIT_W-1:0] wrap_data;

    // checksum lands in the header beat only
    always_comb begin
        wrap_data = beat.data;
        if (beat.is_hdr) begin
            wrap_data[CSUM_LSB +: CSUM_W] = csum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
            out_last  <= 1'b0;
            pkt_done  <= 1'b0;
        end else begin
            out_valid <= beat.valid;
            out_last  <= beat.last;
            // one pulse per packet, with its last output beat
            pkt_done  <= beat.last && (|beat.valid);
        end
        out_data <= wrap_data;
    end

endmodule

// ==== pkt_assembler_assert.sv ====
`timescale 1ns/1ns

module pkt_assembler_assert
    import pkt_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input logic             wb_cyc,
    input logic             wb_stb,
    input logic             wb_ack,
    input logic [LANES-1:0] out_valid,
    input logic             out_last
);

    // one request, one ack pulse
    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles");

    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a preceding request");

    last_has_valid: assert property (@(posedge clk) disable iff (rst)
        out_last |-> (|out_valid))
        else $error("out_last set with no valid lane");

    idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> out_valid == '0)
        else $error("out_valid set right after reset");

endmodule

bind pkt_assembler_top pkt_assembler_assert i_pkt_assembler_assert (
    .clk       (clk),
    .rst       (rst),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .out_valid (out_valid),
    .out_last  (out_last)
);

// ==== pkt_assembler_top.sv ====
`timescale 1ns/1ns

module pkt_assembler_top
    import pkt_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [PHIT_W-1:0]   in_data,
    input  logic [LANES-1:0]    in_valid,
    input  logic                in_last,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    output logic [PHIT_W-1:0]   out_data,
    output logic [LANES-1:0]    out_valid,
    output logic                out_last,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack
);

    logic              enable;
    logic [LEN_W-1:0]  pkt_len;
    logic              pkt_done;
    logic [CSUM_W-1:0] csum;
    beat_t             csu_beat;
    beat_t             dly_beat;

    wb_cfg_regs i_wb_cfg_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .pkt_done (pkt_done),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .enable   (enable),
        .pkt_len  (pkt_len)
    );

    // record leaves after 1 cycle, checksum after CSUM_LAT
    hdr_csum_unit i_hdr_csum_unit (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_last  (in_last),
        .enable   (enable),
        .pkt_len  (pkt_len),
        .beat     (csu_beat),
        .csum     (csum)
    );

    // realigns the record with its checksum
    beat_delay #(
        .T (beat_t)
    ) i_beat_delay (
        .clk (clk),
        .rst (rst),
        .d   (csu_beat),
        .q   (dly_beat)
    );

    packet_rewrap i_packet_rewrap (
        .clk       (clk),
        .rst       (rst),
        .beat      (dly_beat),
        .csum      (csum),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .pkt_done  (pkt_done)
    );

endmodule

// ==== pkt_pkg.sv ====
package pkt_pkg;

    // stream geometry
    localparam int LANES  = 8;
    localparam int LANE_W = 32;
    localparam int PHIT_W = LANES * LANE_W;

    // header fields inside the first beat
    localparam int HDR_WORDS = 10;
    localparam int LEN_LSB   = 16;
    localparam int LEN_W     = 16;
    localparam int CSUM_LSB  = 80;
    localparam int CSUM_W    = 16;
    // wide enough for ten 16-bit words without overflow
    localparam int SUM_W     = 20;

    // pipeline depths
    localparam int CSUM_LAT  = 5;
    localparam int BUF_DEPTH = CSUM_LAT - 1;

    // wishbone register map
    localparam int WB_ADR_W = 2;
    localparam int WB_DAT_W = 32;
    localparam logic [WB_ADR_W-1:0] ADR_CTRL  = 2'd0;
    localparam logic [WB_ADR_W-1:0] ADR_LEN   = 2'd1;
    localparam logic [WB_ADR_W-1:0] ADR_COUNT = 2'd2;

    // one stream beat as it moves through the pipeline
    typedef struct packed {
        logic [PHIT_W-1:0] data;
        logic [LANES-1:0]  valid;
        logic              last;
        logic              is_hdr;
    } beat_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_pkt_assembler -f src.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== src.f ====
pkt_pkg.sv
wb_cfg_regs.sv
hdr_csum_unit.sv
beat_delay.sv
packet_rewrap.sv
pkt_assembler_top.sv
pkt_assembler_assert.sv
tb_pkt_assembler.sv

// ==== tb_pkt_assembler.sv ====
`timescale 1ns/1ns

module tb_pkt_assembler
    import pkt_pkg::*;
();

    localparam int LATENCY    = 6;
    localparam int N_PKTS     = 30;
    localparam int MAX_BEATS  = 5;
    localparam int MAX_GAP    = 3;
    localparam int REG_OPS    = 20;
    // beats, gap and up to one two-cycle register write per beat
    localparam int PKT_CYCLES = MAX_BEATS + MAX_GAP + 2 * (MAX_BEATS + 1);
    localparam int RUN_CYCLES = 3 * N_PKTS * PKT_CYCLES + 2 * REG_OPS + 200;

    typedef struct packed {
        logic [PHIT_W-1:0] data;
        logic [LANES-1:0]  valid;
        logic              last;
        int                tag;
    } exp_t;

    logic                clk      = 1'b0;
    logic                rst      = 1'b1;
    logic [PHIT_W-1:0]   in_data  = '0;
    logic [LANES-1:0]    in_valid = '0;
    logic                in_last  = 1'b0;
    logic                wb_cyc   = 1'b0;
    logic                wb_stb   = 1'b0;
    logic                wb_we    = 1'b0;
    logic [WB_ADR_W-1:0] wb_adr   = '0;
    logic [WB_DAT_W-1:0] wb_dat_w = '0;
    logic [PHIT_W-1:0]   out_data;
    logic [LANES-1:0]    out_valid;
    logic                out_last;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic                wb_ack;

    logic [31:0]      lfsr      = 32'h82d1_c924;
    logic             tb_in_pkt = 1'b0;
    logic             sh_en     = 1'b0;
    logic [LEN_W-1:0] sh_len    = '0;
    exp_t             exp_q[$];
    exp_t             cmp_e;
    int               cyc       = 0;
    int               checks    = 0;
    int               errors    = 0;
    int               err_mark  = 0;
    int               exp_pkts  = 0;

    pkt_assembler_top i_pkt_assembler_top (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_last  (in_last),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .out_data (out_data),
        .out_valid(out_valid),
        .out_last (out_last),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [PHIT_W-1:0] rand_data();
        logic [PHIT_W-1:0] d;
        for (int i = 0; i < LANES; i++) begin
            d[LANE_W*i +: LANE_W] = rand_bits(LANE_W);
        end
        return d;
    endfunction

    function automatic int rand_beats();
        return 1 + int'(rand_bits(3) % 32'd5);
    endfunction

    function automatic logic [CSUM_W-1:0] ref_csum(input logic [PHIT_W-1:0] d,
                                                   input logic [LEN_W-1:0]  len);
        logic [31:0]       sum;
        logic [CSUM_W-1:0] w;
        sum = '0;
        for (int i = 0; i < HDR_WORDS; i++) begin
            w = d[CSUM_W*i +: CSUM_W];
            if (i == LEN_LSB / CSUM_W) begin
                w = len;
            end
            if (i == CSUM_LSB / CSUM_W) begin
                w = '0;
            end
            sum = sum + 32'(w);
        end
        // end-around carry
        while (sum[31:16] != 0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        return ~sum[15:0];
    endfunction

    // expected output data for one input beat
    function automatic logic [PHIT_W-1:0] ref_data(input logic [PHIT_W-1:0] d,
                                                   input logic flag,
                                                   input logic [LEN_W-1:0] len);
        logic [PHIT_W-1:0] r;
        r = d;
        if (flag) begin
            r[LEN_LSB +: LEN_W]   = len;
            r[CSUM_LSB +: CSUM_W] = ref_csum(d, len);
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [PHIT_W-1:0] got,
                         input logic [PHIT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic drive_beat(input logic [PHIT_W-1:0] d, input logic [LANES-1:0] v,
                              input logic l);
        exp_t e;
        logic hdr;
        hdr     = (|v) && !tb_in_pkt;
        e.data  = ref_data(d, hdr && sh_en, sh_len);
        e.valid = v;
        e.last  = l;
        // cycle count while the beat sits on the inputs
        e.tag   = cyc;
        if (|v) begin
            exp_q.push_back(e);
            tb_in_pkt = !l;
            if (l) begin
                exp_pkts++;
            end
        end
        in_data  = d;
        in_valid = v;
        in_last  = l;
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycle();
        in_data  = '0;
        in_valid = '0;
        in_last  = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            idle_cycle();
        end
        repeat (3) begin
            idle_cycle();
        end
    endtask

    task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                             input logic [WB_DAT_W-1:0] wdat,
                             output logic [WB_DAT_W-1:0] rdat);
        in_valid = '0;
        in_last  = 1'b0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // let ack fall before the next request
        @(posedge clk);
        #1;
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
        logic [WB_DAT_W-1:0] unused;
        wb_access(1'b1, adr, dat, unused);
        // shadow of the config registers
        if (adr == ADR_CTRL) begin
            sh_en = dat[0];
        end else if (adr == ADR_LEN) begin
            sh_len = dat[LEN_W-1:0];
        end
    endtask

    task automatic read_reg(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] exp,
                            input string name);
        logic [WB_DAT_W-1:0] rdat;
        wb_access(1'b0, adr, '0, rdat);
        check(name, PHIT_W'(rdat), PHIT_W'(exp));
    endtask

    task automatic send_packet(input int nb, input int gap, input logic mid_toggle);
        logic [LANES-1:0] v;
        for (int b = 0; b < nb; b++) begin
            // header beats carry all lanes
            v = (b == 0) ? '1 : LANES'(rand_bits(LANES));
            if (v == '0) begin
                v = LANES'(1);
            end
            if (mid_toggle && b > 0 && rand_bits(2) == 0) begin
                wb_write(ADR_CTRL, WB_DAT_W'(!sh_en));
            end
            drive_beat(rand_data(), v, b == nb - 1);
        end
        repeat (gap) begin
            idle_cycle();
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (|out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: output beat with no input beat pending", $time);
                end else begin
                    cmp_e = exp_q.pop_front();
                    check("out_data", out_data, cmp_e.data);
                    check("out_valid", PHIT_W'(out_valid), PHIT_W'(cmp_e.valid));
                    check("out_last", PHIT_W'(out_last), PHIT_W'(cmp_e.last));
                    check("arrival_cycle", PHIT_W'(cyc), PHIT_W'(cmp_e.tag + LATENCY));
                end
            end else begin
                check("out_last", PHIT_W'(out_last), '0);
            end
        end
    end

    initial begin
        #(RUN_CYCLES * 10);
        $display("timeout: run did not finish within %0d cycles", RUN_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        int nb;
        int gap;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (8) begin
            idle_cycle();
        end
        end_test("reset_idle");

        read_reg(ADR_CTRL, 0, "ctrl");
        read_reg(ADR_LEN, 0, "len");
        read_reg(ADR_COUNT, 0, "count");
        wb_write(ADR_CTRL, 32'hffff_ffff);
        wb_write(ADR_LEN, 32'habcd_1234);
        wb_write(ADR_COUNT, 32'h0000_0005);
        read_reg(ADR_CTRL, 32'h1, "ctrl");
        read_reg(ADR_LEN, 32'h0000_1234, "len");
        read_reg(ADR_COUNT, 0, "count");
        end_test("registers");

        wb_write(ADR_LEN, rand_bits(16));
        for (int p = 0; p < N_PKTS; p++) begin
            send_packet(rand_beats(), int'(rand_bits(2)), 1'b0);
        end
        drain();
        end_test("enabled");

        wb_write(ADR_CTRL, 32'h0);
        for (int p = 0; p < N_PKTS; p++) begin
            send_packet(rand_beats(), int'(rand_bits(2)), 1'b0);
        end
        drain();
        end_test("disabled");

        // single-beat and back-to-back packets first
        wb_write(ADR_CTRL, 32'h1);
        for (int p = 0; p < N_PKTS; p++) begin
            nb  = (p < 8) ? 1 : rand_beats();
            gap = (p < 12) ? 0 : int'(rand_bits(2));
            if (p >= 12 && rand_bits(1) != 0) begin
                wb_write(ADR_LEN, rand_bits(16));
            end
            send_packet(nb, gap, 1'b1);
        end
        drain();
        end_test("mixed");

        read_reg(ADR_COUNT, WB_DAT_W'(exp_pkts), "pkt_count");
        end_test("packet_count");

        $display("summary: %0d checks, %0d errors, %0d packets", checks, errors, exp_pkts);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== wb_cfg_regs.sv ====
`timescale 1ns/1ns

module wb_cfg_regs
    import pkt_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    input  logic                pkt_done,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack,
    output logic                enable,
    output logic [LEN_W-1:0]    pkt_len
);

    logic                req;
    logic [WB_DAT_W-1:0] pkt_count;
    logic [WB_DAT_W-1:0] rd_mux;

    // new access only while ack is low, so each request acks once
    assign req = wb_cyc && wb_stb && !wb_ack;

    always_comb begin
        case (wb_adr)
            ADR_CTRL:  rd_mux = WB_DAT_W'(enable);
            ADR_LEN:   rd_mux = WB_DAT_W'(pkt_len);
            ADR_COUNT: rd_mux = pkt_count;
            default:   rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            wb_dat_r  <= '0;
            enable    <= 1'b0;
            pkt_len   <= '0;
            pkt_count <= '0;
        end else begin
            wb_ack <= req;
            if (req && !wb_we) begin
                wb_dat_r <= rd_mux;
            end
            // count register is read-only
            if (req && wb_we) begin
                case (wb_adr)
                    ADR_CTRL: enable  <= wb_dat_w[0];
                    ADR_LEN:  pkt_len <= wb_dat_w[LEN_W-1:0];
                    default:  ;
                endcase
            end
            // wraps at 2^32
            if (pkt_done) begin
                pkt_count <= pkt_count + 1'b1;
            end
        end
    end

endmodule
